// File: src/scoreboard_pkg.sv
`default_nettype none

package scoreboard_pkg;

    // Flip-flops in the button input synchronizer, at least 2
    localparam int unsigned SYNC_STAGES = 2;

    // Cycles a new button level must stay stable before it is accepted
    localparam int unsigned DEBOUNCE_CYCLES = 4;

    // Hold time in cycles that turns a press into a correction
    localparam int unsigned LONG_PRESS_CYCLES = 16;

    // Numeric scoring limits
    localparam int unsigned SCORE_MAX = 99;
    localparam int unsigned SCORE_BIG_STEP = 10;

    // Win rule shared by counting and big-steps modes
    localparam int unsigned WIN_POINTS = 11;
    localparam int unsigned WIN_MARGIN = 2;

    // Counter widths sized to hold their terminal values
    localparam int unsigned DEBOUNCE_CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam int unsigned HOLD_CNT_W = $clog2(LONG_PRESS_CYCLES + 1);

    typedef logic [DEBOUNCE_CNT_W-1:0] debounce_cnt_t;
    typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

    // Tennis point ladder, GAME is the only winning point
    typedef enum logic [2:0] {
        LOVE      = 3'd0,
        FIFTEEN   = 3'd1,
        THIRTY    = 3'd2,
        FORTY     = 3'd3,
        ADVANTAGE = 3'd4,
        GAME      = 3'd5
    } tennis_point_e;

    // One-cycle press events from a button chain
    typedef struct packed {
        logic short_press;
        logic long_press;
    } press_t;

    // Tennis reading of a score word
    typedef struct packed {
        logic [4:0]    pad;
        tennis_point_e point;
    } tennis_view_t;

    // One score register, read as a count or as a tennis point
    typedef union packed {
        logic [7:0]   count;
        tennis_view_t tennis;
    } score_u;

endpackage

`default_nettype wire

// File: src/button_debouncer.sv
`default_nettype none

module button_debouncer (
    input  logic clk_i,
    input  logic rst_i,
    input  logic button_i,
    output logic db_o
);

    logic [scoreboard_pkg::SYNC_STAGES-1:0] sync_q;
    logic                                   sync_lvl;
    logic                                   db_q;
    scoreboard_pkg::debounce_cnt_t          stable_cnt_q;

    assign sync_lvl = sync_q[scoreboard_pkg::SYNC_STAGES-1];
    assign db_o     = db_q;

    // Raw button enters at bit 0
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[scoreboard_pkg::SYNC_STAGES-2:0], button_i};
        end
    end

    // Count cycles the synchronized level disagrees with the accepted one
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            db_q         <= 1'b0;
            stable_cnt_q <= '0;
        end else if (sync_lvl == db_q) begin
            stable_cnt_q <= '0;
        end else if (stable_cnt_q ==
                     scoreboard_pkg::debounce_cnt_t'(scoreboard_pkg::DEBOUNCE_CYCLES - 1)) begin
            // New level held long enough
            db_q         <= sync_lvl;
            stable_cnt_q <= '0;
        end else begin
            stable_cnt_q <= stable_cnt_q + 1'b1;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        stable_cnt_q <= scoreboard_pkg::debounce_cnt_t'(scoreboard_pkg::DEBOUNCE_CYCLES));

endmodule

`default_nettype wire

// File: src/press_classifier.sv
`default_nettype none

module press_classifier (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   db_i,
    output scoreboard_pkg::press_t press_o
);

    logic                      prev_q;
    logic                      released;
    logic                      long_sent_q;
    logic                      at_long;
    scoreboard_pkg::hold_cnt_t hold_q;
    scoreboard_pkg::press_t    press_q;

    assign released = prev_q & ~db_i;
    assign press_o  = press_q;

    // Hold count is one short of the threshold on the crossing cycle
    assign at_long = (hold_q ==
        scoreboard_pkg::hold_cnt_t'(scoreboard_pkg::LONG_PRESS_CYCLES - 1));

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            prev_q      <= 1'b0;
            hold_q      <= '0;
            long_sent_q <= 1'b0;
            press_q     <= '0;
        end else begin
            prev_q <= db_i;

            // Release of a press that never crossed the long threshold
            press_q.short_press <= released & ~long_sent_q;

            // Fires once per press while still held
            press_q.long_press <= db_i & at_long;

            if (db_i) begin
                if (hold_q !=
                    scoreboard_pkg::hold_cnt_t'(scoreboard_pkg::LONG_PRESS_CYCLES)) begin
                    hold_q <= hold_q + 1'b1;
                end
                if (at_long) begin
                    long_sent_q <= 1'b1;
                end
            end else begin
                hold_q      <= '0;
                long_sent_q <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        !(press_q.short_press && press_q.long_press));

endmodule

`default_nettype wire

// File: src/score_keeper.sv
`default_nettype none

module score_keeper (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  scoreboard_pkg::press_t p1_press_i,
    input  scoreboard_pkg::press_t p2_press_i,
    input  logic                   mode_tennis_i,
    input  logic                   mode_big_steps_i,
    output logic [7:0]             p1_score_o,
    output logic [7:0]             p2_score_o,
    output logic                   p1_win_o,
    output logic                   p2_win_o
);

    scoreboard_pkg::score_u        p1_q;
    scoreboard_pkg::score_u        p2_q;
    scoreboard_pkg::score_u        p1_d;
    scoreboard_pkg::score_u        p2_d;
    scoreboard_pkg::tennis_point_e p1_pt;
    scoreboard_pkg::tennis_point_e p2_pt;
    logic [1:0]                    mode_q;
    logic                          mode_change;
    logic                          tennis_act;
    logic [7:0]                    step;
    logic                          p1_win_q;
    logic                          p2_win_q;

    // Big steps override tennis
    assign tennis_act  = mode_tennis_i & ~mode_big_steps_i;
    assign step        = mode_big_steps_i ? 8'(scoreboard_pkg::SCORE_BIG_STEP) : 8'd1;
    assign mode_change = (mode_q != {tennis_act, mode_big_steps_i});

    // Saturating step up or down for the numeric modes
    function automatic logic [7:0] count_next(input logic [7:0] cnt,
                                              input scoreboard_pkg::press_t press,
                                              input logic [7:0] inc);
        logic [7:0] result;
        result = cnt;
        if (press.short_press) begin
            if (cnt > 8'(scoreboard_pkg::SCORE_MAX) - inc) begin
                result = 8'(scoreboard_pkg::SCORE_MAX);
            end else begin
                result = cnt + inc;
            end
        end else if (press.long_press) begin
            if (cnt < inc) begin
                result = 8'd0;
            end else begin
                result = cnt - inc;
            end
        end
        return result;
    endfunction

    function automatic logic count_wins(input logic [7:0] own, input logic [7:0] other);
        return (own >= 8'(scoreboard_pkg::WIN_POINTS)) &&
               (own >= other + 8'(scoreboard_pkg::WIN_MARGIN));
    endfunction

    function automatic scoreboard_pkg::tennis_point_e point_back(
        input scoreboard_pkg::tennis_point_e pt);
        if (pt == scoreboard_pkg::LOVE) begin
            return scoreboard_pkg::LOVE;
        end
        return scoreboard_pkg::tennis_point_e'(pt - 3'd1);
    endfunction

    // Point won by one side, may pull the other side back to deuce
    function automatic void point_won(input  scoreboard_pkg::tennis_point_e win_pt,
                                      input  scoreboard_pkg::tennis_point_e lose_pt,
                                      output scoreboard_pkg::tennis_point_e win_nx,
                                      output scoreboard_pkg::tennis_point_e lose_nx);
        win_nx  = win_pt;
        lose_nx = lose_pt;
        // Finished game ignores further points
        if (win_pt != scoreboard_pkg::GAME && lose_pt != scoreboard_pkg::GAME) begin
            case (win_pt)
                scoreboard_pkg::LOVE:      win_nx = scoreboard_pkg::FIFTEEN;
                scoreboard_pkg::FIFTEEN:   win_nx = scoreboard_pkg::THIRTY;
                scoreboard_pkg::THIRTY:    win_nx = scoreboard_pkg::FORTY;
                scoreboard_pkg::FORTY: begin
                    if (lose_pt == scoreboard_pkg::ADVANTAGE) begin
                        lose_nx = scoreboard_pkg::FORTY;
                    end else if (lose_pt == scoreboard_pkg::FORTY) begin
                        win_nx = scoreboard_pkg::ADVANTAGE;
                    end else begin
                        win_nx = scoreboard_pkg::GAME;
                    end
                end
                scoreboard_pkg::ADVANTAGE: win_nx = scoreboard_pkg::GAME;
                default:                   win_nx = win_pt;
            endcase
        end
    endfunction

    always_comb begin
        p1_d  = p1_q;
        p2_d  = p2_q;
        p1_pt = p1_q.tennis.point;
        p2_pt = p2_q.tennis.point;
        if (mode_change) begin
            // Switching rules starts a fresh game
            p1_d = '0;
            p2_d = '0;
        end else if (tennis_act) begin
            // A short press owns the cycle, P1 first
            if (p1_press_i.short_press) begin
                point_won(p1_q.tennis.point, p2_q.tennis.point, p1_pt, p2_pt);
            end else if (p2_press_i.short_press) begin
                point_won(p2_q.tennis.point, p1_q.tennis.point, p2_pt, p1_pt);
            end else begin
                if (p1_press_i.long_press) begin
                    p1_pt = point_back(p1_q.tennis.point);
                end
                if (p2_press_i.long_press) begin
                    p2_pt = point_back(p2_q.tennis.point);
                end
            end
            p1_d.count = {5'd0, p1_pt};
            p2_d.count = {5'd0, p2_pt};
        end else begin
            p1_d.count = count_next(p1_q.count, p1_press_i, step);
            p2_d.count = count_next(p2_q.count, p2_press_i, step);
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            p1_q     <= '0;
            p2_q     <= '0;
            mode_q   <= 2'b00;
            p1_win_q <= 1'b0;
            p2_win_q <= 1'b0;
        end else begin
            p1_q   <= p1_d;
            p2_q   <= p2_d;
            mode_q <= {tennis_act, mode_big_steps_i};
            // Wins follow the registered scores by one cycle
            if (tennis_act) begin
                p1_win_q <= (p1_q.tennis.point == scoreboard_pkg::GAME);
                p2_win_q <= (p2_q.tennis.point == scoreboard_pkg::GAME);
            end else begin
                p1_win_q <= count_wins(p1_q.count, p2_q.count);
                p2_win_q <= count_wins(p2_q.count, p1_q.count);
            end
        end
    end

    assign p1_score_o = p1_q.count;
    assign p2_score_o = p2_q.count;
    assign p1_win_o   = p1_win_q;
    assign p2_win_o   = p2_win_q;

    assert property (@(posedge clk_i) disable iff (rst_i)
        (!tennis_act && !mode_change) |->
            (p1_q.count <= 8'(scoreboard_pkg::SCORE_MAX) &&
             p2_q.count <= 8'(scoreboard_pkg::SCORE_MAX)));

    assert property (@(posedge clk_i) disable iff (rst_i)
        (tennis_act && !mode_change) |->
            (p1_q.tennis.point <= scoreboard_pkg::GAME &&
             p2_q.tennis.point <= scoreboard_pkg::GAME));

endmodule

`default_nettype wire

// File: src/scoreboard_top.sv
`default_nettype none

module scoreboard_top (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       p1_button_i,
    input  logic       p2_button_i,
    input  logic       mode_tennis_i,
    input  logic       mode_big_steps_i,
    output logic [7:0] p1_score_o,
    output logic [7:0] p2_score_o,
    output logic       p1_win_o,
    output logic       p2_win_o
);

    logic                   p1_db;
    logic                   p2_db;
    scoreboard_pkg::press_t p1_press;
    scoreboard_pkg::press_t p2_press;

    // Player 1 button chain
    button_debouncer i_p1_debouncer (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .button_i (p1_button_i),
        .db_o     (p1_db)
    );

    press_classifier i_p1_classifier (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .db_i    (p1_db),
        .press_o (p1_press)
    );

    // Player 2 button chain
    button_debouncer i_p2_debouncer (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .button_i (p2_button_i),
        .db_o     (p2_db)
    );

    press_classifier i_p2_classifier (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .db_i    (p2_db),
        .press_o (p2_press)
    );

    score_keeper i_score_keeper (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .p1_press_i       (p1_press),
        .p2_press_i       (p2_press),
        .mode_tennis_i    (mode_tennis_i),
        .mode_big_steps_i (mode_big_steps_i),
        .p1_score_o       (p1_score_o),
        .p2_score_o       (p2_score_o),
        .p1_win_o         (p1_win_o),
        .p2_win_o         (p2_win_o)
    );

endmodule

`default_nettype wire

// File: testbench/scoreboard_tb.sv
`default_nettype none

module scoreboard_tb;

    localparam int CLK_HALF = 10;
    localparam int MAX_STEPS = 128;
    localparam int GLITCHES = 3;
    localparam int DEBOUNCE = int'(scoreboard_pkg::DEBOUNCE_CYCLES);
    localparam int SHORT_HOLD = int'(scoreboard_pkg::LONG_PRESS_CYCLES) / 2;
    localparam int LONG_HOLD = int'(scoreboard_pkg::LONG_PRESS_CYCLES) + 6;
    // Release to settled win flag is sync + debounce + 3, plus margin
    localparam int SETTLE_CYCLES = int'(scoreboard_pkg::SYNC_STAGES) + DEBOUNCE + 9;
    localparam int WATCHDOG_CYCLES = 20000;
    localparam logic [35:0] END_MARK = 36'hf_ffff_ffff;

    logic       clk;
    logic       rst;
    logic       p1_button;
    logic       p2_button;
    logic       mode_tennis;
    logic       mode_big_steps;
    logic [7:0] p1_score;
    logic [7:0] p2_score;
    logic       p1_win;
    logic       p2_win;

    logic [35:0] patterns [MAX_STEPS];
    logic [31:0] lfsr;
    int          mismatch_cnt;
    int          other_err_cnt;

    scoreboard_top i_scoreboard_top (
        .clk_i            (clk),
        .rst_i            (rst),
        .p1_button_i      (p1_button),
        .p2_button_i      (p2_button),
        .mode_tennis_i    (mode_tennis),
        .mode_big_steps_i (mode_big_steps),
        .p1_score_o       (p1_score),
        .p2_score_o       (p2_score),
        .p1_win_o         (p1_win),
        .p2_win_o         (p2_win)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Hard stop in case a step never finishes
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < WATCHDOG_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run went past %0d clock cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic wait_falling(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
    endtask

    function automatic int hold_cycles(input logic [3:0] action);
        case (action)
            4'd1:    return SHORT_HOLD;
            4'd2:    return LONG_HOLD;
            default: return 0;
        endcase
    endfunction

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Mismatch %s %s: expected %0d, actual %0d", name, what, expected, actual);
            mismatch_cnt++;
        end
    endtask

    // Word layout M A B F PP QQ W, one hex digit per field except scores
    task automatic perform_step(input logic [35:0] pat);
        int   hold1;
        int   hold2;
        int   max_hold;
        int   len;
        int   gap;
        logic bounce1;
        logic bounce2;
        hold1 = hold_cycles(pat[31:28]);
        hold2 = hold_cycles(pat[27:24]);
        max_hold = (hold1 > hold2) ? hold1 : hold2;
        // Glitch only the pressed buttons, or both when nobody presses
        bounce1 = (hold1 > 0) || (hold2 == 0);
        bounce2 = (hold2 > 0) || (hold1 == 0);

        mode_tennis    = pat[32];
        mode_big_steps = pat[33];
        wait_falling(3);

        if (pat[20]) begin
            for (int g = 0; g < GLITCHES; g++) begin
                take_bits(2, len);
                take_bits(2, gap);
                p1_button = bounce1;
                p2_button = bounce2;
                // Always shorter than the debounce time
                wait_falling(1 + len % (DEBOUNCE - 1));
                p1_button = 1'b0;
                p2_button = 1'b0;
                wait_falling(1 + gap);
            end
        end

        for (int i = 0; i < max_hold; i++) begin
            p1_button = i < hold1;
            p2_button = i < hold2;
            @(negedge clk);
        end
        p1_button = 1'b0;
        p2_button = 1'b0;
        wait_falling(SETTLE_CYCLES);
    endtask

    initial begin
        int    n_steps;
        string name;
        rst            = 1'b1;
        p1_button      = 1'b0;
        p2_button      = 1'b0;
        mode_tennis    = 1'b0;
        mode_big_steps = 1'b0;
        mismatch_cnt   = 0;
        other_err_cnt  = 0;
        lfsr           = 32'haa2c_041b;
        for (int i = 0; i < MAX_STEPS; i++) begin
            patterns[i] = END_MARK;
        end
        $readmemh("testbench/scoreboard_patterns.txt", patterns);

        wait_falling(2);
        rst = 1'b0;

        n_steps = 0;
        while (n_steps < MAX_STEPS && patterns[n_steps] != END_MARK) begin
            n_steps++;
        end
        assert (n_steps > 0) else begin
            $display("The pattern file gave no steps to run");
            other_err_cnt++;
        end
        assert (n_steps < MAX_STEPS) else begin
            $display("No end marker found within %0d pattern entries", MAX_STEPS);
            other_err_cnt++;
        end

        for (int s = 0; s < n_steps; s++) begin
            name = $sformatf("step %0d", s + 1);
            perform_step(patterns[s]);
            check_value(name, "p1 score", int'(patterns[s][19:12]), int'(p1_score));
            check_value(name, "p2 score", int'(patterns[s][11:4]), int'(p2_score));
            check_value(name, "p1 win", int'(patterns[s][1]), int'(p1_win));
            check_value(name, "p2 win", int'(patterns[s][0]), int'(p2_win));
        end

        $display("Steps run %0d, mismatches %0d, other errors %0d",
                 n_steps, mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/scoreboard_patterns.txt
// One step per line as hex digits M A B F PP QQ W
// M mode (bit0 tennis, bit1 big steps), A and B action (0 none, 1 short, 2 long)
// F bounce, PP and QQ expected scores, W expected wins (bit1 p1, bit0 p2)
// Counting mode
000000000
000100000
010101000
010002000
020001000
022000000
011001010
011002020
011003030
011004040
011105050
011006060
011007070
011008080
011009090
01000A090
01000B092
00100B0A0
01000C0A2
02000B0A0
// Big steps, then both mode bits set
21210A000
2110140A2
21101E142
2110281E2
211032282
21103C322
2110463C2
211050462
21105A502
310063502
310063502
3010635A2
301063630
320059631
// Tennis straight game and corrections
110001000
110102000
110003000
110005002
110005002
101005002
120004000
120003000
000000000
// Tennis deuce
110001000
101001010
110002010
101002020
110003020
101003030
110004030
101003030
111104030
101003030
101003040
101003051
102003040
// End marker
fffffffff

// File: project.f
src/scoreboard_pkg.sv
src/button_debouncer.sv
src/press_classifier.sv
src/score_keeper.sv
src/scoreboard_top.sv
testbench/scoreboard_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=scoreboard_sim
LOG=sim.log

verilator --binary --timing --assert -f project.f \
    --top-module scoreboard_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0
